// File: hw/cpu_pkg.sv
package cpu_pkg;

  localparam int word_w     = 32;
  localparam int half_w     = 16;
  localparam int reg_addr_w = 5;

  localparam logic [word_w-1:0] reset_pc = 32'hffc00000; // boot monitor base

  typedef enum logic [2:0] {
    mode_inh2   = 3'h0,
    mode_imm3   = 3'h1,
    mode_regind = 3'h2,
    mode_reg    = 3'h3,
    mode_inh    = 3'h4,
    mode_imm2   = 3'h5,
    mode_dir    = 3'h6,
    mode_imm3a  = 3'h7
  } mode_e;

  typedef enum logic [3:0] {
    alu_and = 4'h0,
    alu_or  = 4'h1,
    alu_add = 4'h2,
    alu_sub = 4'h3,
    alu_xor = 4'h4,
    alu_shl = 4'h5,
    alu_shr = 4'h6
  } alu_op_e;

  typedef enum logic [3:0] {
    br_bra  = 4'h0,
    br_beq  = 4'h1,
    br_bne  = 4'h2,
    br_bgtu = 4'h3,
    br_bgt  = 4'h4,
    br_bge  = 4'h5,
    br_ble  = 4'h6,
    br_blt  = 4'h7,
    br_bgeu = 4'h8,
    br_bltu = 4'h9,
    br_bleu = 4'ha,
    br_brn  = 4'hb
  } br_cond_e;

  // op taken from ir[28:26] in inh mode
  typedef enum logic [2:0] {
    inh_nop = 3'h0,
    inh_cmp = 3'h2,
    inh_inc = 3'h3,
    inh_dec = 3'h4,
    inh_mov = 3'h7
  } inh_op_e;

  typedef enum logic [7:0] {
    op_st_l = 8'h00, // st.l and std.l
    op_ld_l = 8'h01, // ld.l and ldd.l
    op_lda  = 8'h0a,
    op_ldis = 8'h10,
    op_ldiu = 8'h11,
    op_jmpd = 8'h80,
    op_jmp  = 8'ha0
  } op_e;

  typedef struct packed {
    logic [word_w-1:0] ir;      // first halfword on top
    logic [half_w-1:0] ext;     // third halfword
    logic [word_w-1:0] next_pc;
  } instr_t;

  typedef struct packed {
    logic carry;
    logic negative;
    logic overflow;
    logic zero;
  } ccr_t;

endpackage

// File: hw/mem_bus_if.sv
`timescale 1ns/100ps

interface mem_bus_if;

  logic                       valid;
  logic                       write;
  logic [cpu_pkg::word_w-1:0] addr;  // byte address
  logic [cpu_pkg::half_w-1:0] wdata;
  logic                       ready;
  logic [cpu_pkg::half_w-1:0] rdata; // sampled with valid and ready

  modport master (
    output valid, write, addr, wdata,
    input  ready, rdata
  );

  modport slave (
    input  valid, write, addr, wdata,
    output ready, rdata
  );

endinterface

// File: hw/ls_if.sv
`timescale 1ns/100ps

interface ls_if;

  logic                       req_valid;
  logic                       write;
  logic [cpu_pkg::word_w-1:0] addr;
  logic [cpu_pkg::word_w-1:0] wdata;
  logic                       req_ready;
  logic                       done;  // one cycle after the low half
  logic [cpu_pkg::word_w-1:0] rdata;

  modport master (
    output req_valid, write, addr, wdata,
    input  req_ready, done, rdata
  );

  modport slave (
    input  req_valid, write, addr, wdata,
    output req_ready, done, rdata
  );

endinterface

// File: hw/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
  input  logic                       clk,
  input  logic                       rst_n,
  mem_bus_if.master                  bus,
  output logic                       instr_valid,
  output cpu_pkg::instr_t            instr,
  input  logic                       instr_ready,
  input  logic                       pc_valid,
  input  logic [cpu_pkg::word_w-1:0] pc_next
);

  typedef enum logic [1:0] {f_fetch, f_offer, f_wait} state_e;

  state_e                     state;
  logic [cpu_pkg::word_w-1:0] pc;
  logic [1:0]                 cnt; // halfwords taken so far
  logic [cpu_pkg::word_w-1:0] ir;
  logic [cpu_pkg::half_w-1:0] ext;
  logic                       xfer;
  logic [1:0]                 need;

  function automatic logic [1:0] instr_len(cpu_pkg::mode_e m);
    case (m)
      cpu_pkg::mode_inh: return 2'd1;
      cpu_pkg::mode_imm3, cpu_pkg::mode_imm3a, cpu_pkg::mode_dir: return 2'd3;
      default: return 2'd2;
    endcase
  endfunction

  assign xfer = bus.valid && bus.ready;
  // the mode is still on the bus while the first halfword lands
  assign need = instr_len(cpu_pkg::mode_e'((cnt == 2'd0) ? bus.rdata[15:13] : ir[31:29]));

  assign bus.valid = (state == f_fetch);
  assign bus.write = 1'b0;
  assign bus.addr  = pc;
  assign bus.wdata = '0;

  assign instr_valid = (state == f_offer);
  assign instr       = '{ir: ir, ext: ext, next_pc: pc};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= f_fetch;
      pc    <= cpu_pkg::reset_pc;
      cnt   <= 2'd0;
    end else begin
      case (state)
        f_fetch: if (xfer) begin
          pc <= pc + 32'd2;
          if (cnt + 2'd1 == need) begin
            cnt   <= 2'd0;
            state <= f_offer;
          end else begin
            cnt <= cnt + 2'd1;
          end
        end
        f_offer: if (instr_ready) state <= f_wait;
        f_wait: if (pc_valid) begin
          pc    <= pc_next;
          state <= f_fetch;
        end
        default: state <= f_fetch;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      case (cnt)
        2'd0: begin
          ir  <= {bus.rdata, 16'h0000};
          ext <= '0;
        end
        2'd1: ir[15:0] <= bus.rdata;
        default: ext <= bus.rdata;
      endcase
    end
  end

endmodule

// File: hw/load_store_unit.sv
`timescale 1ns/100ps

module load_store_unit (
  input  logic      clk,
  input  logic      rst_n,
  mem_bus_if.master bus,
  ls_if.slave       req
);

  typedef enum logic [1:0] {ls_idle, ls_high, ls_low} state_e;

  state_e                     state;
  logic                       write_q;
  logic                       done_q;
  logic [cpu_pkg::word_w-1:0] addr_q;
  logic [cpu_pkg::word_w-1:0] wdata_q;
  logic [cpu_pkg::word_w-1:0] rdata_q;
  logic                       xfer;

  assign xfer = bus.valid && bus.ready;

  // big-endian with the high half at addr
  assign bus.valid = (state != ls_idle);
  assign bus.write = write_q;
  assign bus.addr  = (state == ls_low) ? addr_q + 32'd2 : addr_q;
  assign bus.wdata = (state == ls_low) ? wdata_q[15:0] : wdata_q[31:16];

  assign req.req_ready = (state == ls_idle);
  assign req.done      = done_q;
  assign req.rdata     = rdata_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ls_idle;
      write_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= (state == ls_low) && xfer;
      case (state)
        ls_idle: if (req.req_valid) begin
          write_q <= req.write;
          state   <= ls_high;
        end
        ls_high: if (xfer) state <= ls_low;
        ls_low:  if (xfer) state <= ls_idle;
        default: state <= ls_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ls_idle && req.req_valid) begin
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
    end
    if (xfer && state == ls_high) rdata_q[31:16] <= bus.rdata;
    if (xfer && state == ls_low) rdata_q[15:0] <= bus.rdata;
  end

endmodule

// File: hw/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter (
  input  logic      clk,
  input  logic      rst_n,
  mem_bus_if.slave  fetch_bus,
  mem_bus_if.slave  ls_bus,
  mem_bus_if.master mem
);

  typedef enum logic [1:0] {grant_none, grant_fetch, grant_ls} grant_e;

  grant_e grant_q;
  logic   sel_ls;

  // load/store wins a fresh tie and a held grant rides out ready stalls
  assign sel_ls = (grant_q == grant_ls) || (grant_q == grant_none && ls_bus.valid);

  assign mem.valid = sel_ls ? ls_bus.valid : fetch_bus.valid;
  assign mem.write = sel_ls ? ls_bus.write : fetch_bus.write;
  assign mem.addr  = sel_ls ? ls_bus.addr  : fetch_bus.addr;
  assign mem.wdata = sel_ls ? ls_bus.wdata : fetch_bus.wdata;

  assign ls_bus.ready    = sel_ls && mem.ready;
  assign fetch_bus.ready = !sel_ls && mem.ready;
  assign ls_bus.rdata    = sel_ls ? mem.rdata : '0;
  assign fetch_bus.rdata = sel_ls ? '0 : mem.rdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_q <= grant_none;
    end else if (mem.valid && mem.ready) begin
      grant_q <= grant_none;
    end else if (mem.valid) begin
      grant_q <= sel_ls ? grant_ls : grant_fetch; // lock until done
    end
  end

endmodule

// File: hw/alu.sv
`timescale 1ns/100ps

module alu (
  input  cpu_pkg::alu_op_e           op,
  input  logic [cpu_pkg::word_w-1:0] a,
  input  logic [cpu_pkg::word_w-1:0] b,
  output logic [cpu_pkg::word_w-1:0] y,
  output cpu_pkg::ccr_t              flags
);

  logic [cpu_pkg::word_w:0] sum;
  logic [cpu_pkg::word_w:0] diff;
  logic                     carry;
  logic                     ovf;

  assign sum  = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} - {1'b0, b}; // top bit is the borrow

  always_comb begin
    carry = 1'b0;
    ovf   = 1'b0;
    case (op)
      cpu_pkg::alu_and: y = a & b;
      cpu_pkg::alu_or:  y = a | b;
      cpu_pkg::alu_add: begin
        y     = sum[31:0];
        carry = sum[32];
        ovf   = (a[31] == b[31]) && (y[31] != a[31]);
      end
      cpu_pkg::alu_sub: begin
        y     = diff[31:0];
        carry = diff[32];
        ovf   = (a[31] != b[31]) && (y[31] != a[31]);
      end
      cpu_pkg::alu_xor: y = a ^ b;
      cpu_pkg::alu_shl: y = a << b[4:0];
      cpu_pkg::alu_shr: y = a >> b[4:0]; // logical
      default: y = '0;
    endcase
  end

  assign flags = '{carry: carry, negative: y[31], overflow: ovf, zero: (y == '0)};

endmodule

// File: hw/regfile.sv
`timescale 1ns/100ps

module regfile (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [cpu_pkg::reg_addr_w-1:0] raddr1,
  input  logic [cpu_pkg::reg_addr_w-1:0] raddr2,
  output logic [cpu_pkg::word_w-1:0]     rdata1,
  output logic [cpu_pkg::word_w-1:0]     rdata2,
  input  logic                           we,
  input  logic [cpu_pkg::reg_addr_w-1:0] waddr,
  input  logic [cpu_pkg::word_w-1:0]     wdata
);

  logic [cpu_pkg::word_w-1:0] regs [2**cpu_pkg::reg_addr_w];

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**cpu_pkg::reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

// File: hw/exec_control.sv
`timescale 1ns/100ps

module exec_control (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           instr_valid,
  input  cpu_pkg::instr_t                instr,
  output logic                           instr_ready,
  output logic                           pc_valid,
  output logic [cpu_pkg::word_w-1:0]     pc_next,
  ls_if.master                           ls,
  output cpu_pkg::alu_op_e               alu_op,
  output logic [cpu_pkg::word_w-1:0]     alu_a,
  output logic [cpu_pkg::word_w-1:0]     alu_b,
  input  logic [cpu_pkg::word_w-1:0]     alu_y,
  input  cpu_pkg::ccr_t                  alu_flags,
  output logic [cpu_pkg::reg_addr_w-1:0] raddr1,
  output logic [cpu_pkg::reg_addr_w-1:0] raddr2,
  input  logic [cpu_pkg::word_w-1:0]     rdata1,
  input  logic [cpu_pkg::word_w-1:0]     rdata2,
  output logic                           we,
  output logic [cpu_pkg::reg_addr_w-1:0] waddr,
  output logic [cpu_pkg::word_w-1:0]     wdata,
  output cpu_pkg::ccr_t                  ccr
);

  typedef enum logic [1:0] {ex_idle, ex_exec, ex_mem, ex_fault} state_e;

  state_e                         state;
  cpu_pkg::instr_t                iq;
  cpu_pkg::ccr_t                  ccr_q;
  logic                           mem_fin_q;
  cpu_pkg::mode_e                 mode;
  logic [7:0]                     op;
  logic [cpu_pkg::reg_addr_w-1:0] ra;
  logic [cpu_pkg::reg_addr_w-1:0] rb;
  logic [cpu_pkg::reg_addr_w-1:0] rc;
  logic [cpu_pkg::word_w-1:0]     imm;
  logic [cpu_pkg::word_w-1:0]     abs_addr;
  logic [cpu_pkg::word_w-1:0]     res;
  logic [cpu_pkg::word_w-1:0]     target;
  logic [cpu_pkg::word_w-1:0]     mem_addr;
  logic                           illegal;
  logic                           write_rf;
  logic                           set_ccr;
  logic                           mem_op;
  logic                           mem_wr;
  logic                           jump;

  function automatic logic br_taken(cpu_pkg::br_cond_e c, cpu_pkg::ccr_t f);
    case (c)
      cpu_pkg::br_bra:  return 1'b1;
      cpu_pkg::br_beq:  return f.zero;
      cpu_pkg::br_bne:  return !f.zero;
      cpu_pkg::br_bgtu: return !(f.zero || f.carry);
      cpu_pkg::br_bgt:  return !(f.zero || (f.negative ^ f.overflow));
      cpu_pkg::br_bge:  return !(f.negative ^ f.overflow);
      cpu_pkg::br_ble:  return f.zero || (f.negative ^ f.overflow);
      cpu_pkg::br_blt:  return f.negative ^ f.overflow;
      cpu_pkg::br_bgeu: return !f.carry;
      cpu_pkg::br_bltu: return f.carry;
      cpu_pkg::br_bleu: return f.carry || f.zero;
      default: return 1'b0; // brn
    endcase
  endfunction

  assign mode = cpu_pkg::mode_e'(iq.ir[31:29]);
  assign op   = iq.ir[31] ? iq.ir[28:21] : {iq.ir[28:26], iq.ir[15:11]};
  assign ra   = iq.ir[20:16];
  assign rb   = iq.ir[25:21];
  assign rc   = iq.ir[4:0];
  // imm3 carries its immediate in the third halfword
  assign imm = (mode == cpu_pkg::mode_imm3) ? {{16{iq.ext[15]}}, iq.ext}
                                            : {{16{iq.ir[15]}}, iq.ir[15:0]};
  assign abs_addr = {iq.ir[15:0], iq.ext};

  assign raddr1 = (mode == cpu_pkg::mode_inh) ? ra : rb;
  assign raddr2 = (mode == cpu_pkg::mode_inh) ? rb :
                  (mode == cpu_pkg::mode_reg) ? rc : ra;

  always_comb begin
    alu_op   = cpu_pkg::alu_add;
    alu_a    = rdata1;
    alu_b    = rdata2;
    res      = alu_y;
    target   = alu_y;
    mem_addr = alu_y;
    write_rf = 1'b0;
    set_ccr  = 1'b0;
    mem_op   = 1'b0;
    mem_wr   = 1'b0;
    jump     = 1'b0;
    illegal  = 1'b0;
    case (mode)
      cpu_pkg::mode_inh: begin
        case (cpu_pkg::inh_op_e'(iq.ir[28:26]))
          cpu_pkg::inh_nop: ;
          cpu_pkg::inh_cmp: begin
            alu_op  = cpu_pkg::alu_sub; // rA - rB
            set_ccr = 1'b1;
          end
          cpu_pkg::inh_inc: begin
            alu_b    = 32'd1;
            write_rf = 1'b1;
          end
          cpu_pkg::inh_dec: begin
            alu_op   = cpu_pkg::alu_sub;
            alu_b    = 32'd1;
            write_rf = 1'b1;
          end
          cpu_pkg::inh_mov: begin
            res      = rdata2;
            write_rf = 1'b1;
          end
          default: illegal = 1'b1;
        endcase
      end
      cpu_pkg::mode_reg, cpu_pkg::mode_imm3: begin
        alu_op = cpu_pkg::alu_op_e'(op[3:0]);
        if (mode == cpu_pkg::mode_imm3) alu_b = imm;
        write_rf = 1'b1;
        illegal  = (op > 8'h06);
      end
      cpu_pkg::mode_imm2: begin
        if (op == cpu_pkg::op_ldis) begin
          res      = imm;
          write_rf = 1'b1;
        end else if (op == cpu_pkg::op_ldiu) begin
          res      = {16'h0000, iq.ir[15:0]};
          write_rf = 1'b1;
        end else if (op <= 8'(cpu_pkg::br_brn)) begin
          jump   = br_taken(cpu_pkg::br_cond_e'(op[3:0]), ccr_q);
          target = iq.next_pc + imm;
        end else begin
          illegal = 1'b1;
        end
      end
      cpu_pkg::mode_imm3a: begin
        res      = abs_addr;
        write_rf = 1'b1;
        illegal  = (op != 8'h00); // ldi is the only one
      end
      cpu_pkg::mode_regind: begin
        alu_b = {{21{iq.ir[10]}}, iq.ir[10:0]}; // rB plus offset
        case (op)
          cpu_pkg::op_st_l: begin
            mem_op = 1'b1;
            mem_wr = 1'b1;
          end
          cpu_pkg::op_ld_l: mem_op = 1'b1;
          cpu_pkg::op_lda:  write_rf = 1'b1;
          cpu_pkg::op_jmp:  jump = 1'b1;
          default: illegal = 1'b1;
        endcase
      end
      cpu_pkg::mode_dir: begin
        mem_addr = abs_addr;
        target   = abs_addr;
        case (op)
          cpu_pkg::op_st_l: begin
            mem_op = 1'b1;
            mem_wr = 1'b1;
          end
          cpu_pkg::op_ld_l: mem_op = 1'b1;
          cpu_pkg::op_jmpd: jump = 1'b1;
          default: illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1; // inh2 has nothing left
    endcase
  end

  assign instr_ready = (state == ex_idle);
  assign pc_valid    = (state == ex_exec && !illegal && !mem_op) || mem_fin_q;
  assign pc_next     = jump ? target : iq.next_pc;

  assign we    = (state == ex_exec) ? (write_rf && !illegal)
                                    : (state == ex_mem && ls.done && !mem_wr);
  assign waddr = ra;
  assign wdata = (state == ex_mem) ? ls.rdata : res;
  assign ccr   = ccr_q;

  assign ls.req_valid = (state == ex_exec) && mem_op;
  assign ls.write     = mem_wr;
  assign ls.addr      = mem_addr;
  assign ls.wdata     = rdata2; // rA

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ex_idle;
      ccr_q     <= '0;
      mem_fin_q <= 1'b0;
    end else begin
      mem_fin_q <= (state == ex_mem) && ls.done;
      if (state == ex_exec && set_ccr && !illegal) ccr_q <= alu_flags;
      case (state)
        ex_idle: if (instr_valid) state <= ex_exec;
        ex_exec: begin
          if (illegal) begin
            state <= ex_fault;
          end else if (!mem_op) begin
            state <= ex_idle;
          end else if (ls.req_ready) begin
            state <= ex_mem;
          end
        end
        ex_mem: if (ls.done) state <= ex_idle;
        default: state <= ex_fault; // stuck until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ex_idle && instr_valid) iq <= instr;
  end

endmodule

// File: hw/cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
  input  logic                       clk,
  input  logic                       rst_n,
  output logic                       mem_valid,
  output logic                       mem_write,
  output logic [cpu_pkg::word_w-1:0] mem_addr,
  output logic [cpu_pkg::half_w-1:0] mem_wdata,
  input  logic                       mem_ready,
  input  logic [cpu_pkg::half_w-1:0] mem_rdata,
  output logic [3:0]                 ccr
);

  mem_bus_if fetch_bus ();
  mem_bus_if ls_bus ();
  mem_bus_if mem_bus ();
  ls_if      ls ();

  logic                           instr_valid;
  logic                           instr_ready;
  cpu_pkg::instr_t                instr;
  logic                           pc_valid;
  logic [cpu_pkg::word_w-1:0]     pc_next;
  cpu_pkg::alu_op_e               alu_op;
  logic [cpu_pkg::word_w-1:0]     alu_a;
  logic [cpu_pkg::word_w-1:0]     alu_b;
  logic [cpu_pkg::word_w-1:0]     alu_y;
  cpu_pkg::ccr_t                  alu_flags;
  cpu_pkg::ccr_t                  ccr_s;
  logic [cpu_pkg::reg_addr_w-1:0] raddr1;
  logic [cpu_pkg::reg_addr_w-1:0] raddr2;
  logic [cpu_pkg::reg_addr_w-1:0] waddr;
  logic [cpu_pkg::word_w-1:0]     rdata1;
  logic [cpu_pkg::word_w-1:0]     rdata2;
  logic [cpu_pkg::word_w-1:0]     wdata;
  logic                           we;

  assign mem_valid     = mem_bus.valid;
  assign mem_write     = mem_bus.write;
  assign mem_addr      = mem_bus.addr;
  assign mem_wdata     = mem_bus.wdata;
  assign mem_bus.ready = mem_ready;
  assign mem_bus.rdata = mem_rdata;
  assign ccr           = ccr_s;

  fetch_unit fetch_unit_i (
    .clk, .rst_n, .bus(fetch_bus), .instr_valid, .instr, .instr_ready, .pc_valid, .pc_next
  );

  load_store_unit load_store_unit_i (.clk, .rst_n, .bus(ls_bus), .req(ls));

  bus_arbiter bus_arbiter_i (.clk, .rst_n, .fetch_bus(fetch_bus), .ls_bus(ls_bus), .mem(mem_bus));

  exec_control exec_control_i (
    .clk, .rst_n, .instr_valid, .instr, .instr_ready, .pc_valid, .pc_next, .ls(ls),
    .alu_op, .alu_a, .alu_b, .alu_y, .alu_flags, .raddr1, .raddr2, .rdata1, .rdata2,
    .we, .waddr, .wdata, .ccr(ccr_s)
  );

  alu alu_i (.op(alu_op), .a(alu_a), .b(alu_b), .y(alu_y), .flags(alu_flags));

  regfile regfile_i (
    .clk, .rst_n, .raddr1, .raddr2, .rdata1, .rdata2, .we, .waddr, .wdata
  );

endmodule

// File: bench/tb_cpu_top.sv
`timescale 1ns/100ps

module tb_cpu_top;

  localparam int timeout_cycles = 2000;
  localparam int quiet_cycles   = 200;
  localparam logic [31:0] preload_addr = 32'h0000_3000;
  localparam logic [31:0] preload_word = 32'h9e37_79b9;

  logic        clk;
  logic        rst_n;
  logic        mem_valid;
  logic        mem_write;
  logic [31:0] mem_addr;
  logic [15:0] mem_wdata;
  logic        mem_ready;
  logic [15:0] mem_rdata;
  logic [3:0]  ccr;

  logic [31:0] rng_state = 32'd34238;

  logic [15:0] prog_mem [logic [31:0]]; // offset from reset_pc
  logic [15:0] data_mem [logic [31:0]]; // raw byte address

  // operand pairs for the register ops, cmp and branches
  logic [31:0] pair_a [3] = '{32'h8000_0011, 32'h0000_0005, 32'h0000_0003};
  logic [31:0] pair_b [3] = '{32'h0000_0f0c, 32'h0000_0005, 32'hffff_fff0};

  logic [15:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [15:0] exp_data [$];
  logic [3:0]  exp_ccr [$];
  logic [31:0] regs_m [32]; // register model
  logic [3:0]  ccr_m;       // carry, negative, overflow, zero
  logic [31:0] dptr;

  cpu_top cpu_top_i (
    .clk, .rst_n, .mem_valid, .mem_write, .mem_addr, .mem_wdata, .mem_ready, .mem_rdata, .ccr
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp));
    end
  endtask

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // whole address folded in
  function automatic logic [15:0] fill_value(input logic [31:0] addr);
    return addr[31:16] ^ addr[15:0] ^ 16'hc3a5;
  endfunction

  function automatic logic [15:0] mem_read(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - cpu_pkg::reset_pc;
    if (addr >= cpu_pkg::reset_pc) begin
      return prog_mem.exists(off) ? prog_mem[off] : fill_value(addr);
    end
    return data_mem.exists(addr) ? data_mem[addr] : fill_value(addr);
  endfunction

  function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a, b);
    case (op)
      4'h0: return a & b;
      4'h1: return a | b;
      4'h2: return a + b;
      4'h3: return a - b;
      4'h4: return a ^ b;
      4'h5: return a << b[4:0];
      default: return a >> b[4:0];
    endcase
  endfunction

  function automatic logic [3:0] sub_flags(input logic [31:0] a, b);
    logic [31:0]        d;
    logic signed [32:0] sd;
    d  = a - b;
    sd = $signed({a[31], a}) - $signed({b[31], b}); // out of 32-bit range means overflow
    return {a < b, d[31], sd[32] != sd[31], d == 32'd0};
  endfunction

  function automatic logic branch_rule(input logic [3:0] cond, input logic [3:0] f);
    logic c, n, v, z;
    {c, n, v, z} = f;
    case (cond)
      4'h0: return 1'b1;
      4'h1: return z;
      4'h2: return !z;
      4'h3: return !(c || z);
      4'h4: return !(z || (n ^ v));
      4'h5: return !(n ^ v);
      4'h6: return z || (n ^ v);
      4'h7: return n ^ v;
      4'h8: return !c;
      4'h9: return c;
      4'ha: return c || z;
      default: return 1'b0; // brn
    endcase
  endfunction

  function automatic logic [31:0] pc_now();
    return cpu_pkg::reset_pc + 32'(prog.size() * 2);
  endfunction

  task automatic put_half(input logic [15:0] hw);
    prog.push_back(hw);
  endtask

  task automatic expect_word(input logic [31:0] addr, input logic [31:0] val);
    exp_addr.push_back(addr);
    exp_data.push_back(val[31:16]); // high half first
    exp_ccr.push_back(ccr_m);
    exp_addr.push_back(addr + 32'd2);
    exp_data.push_back(val[15:0]);
    exp_ccr.push_back(ccr_m);
  endtask

  task automatic load_imm32(input logic [4:0] ra, input logic [31:0] val);
    put_half({3'b111, 8'h00, ra});
    put_half(val[31:16]);
    put_half(val[15:0]);
    regs_m[ra] = val;
  endtask

  task automatic load_imm16(input logic sign, input logic [4:0] ra, input logic [15:0] imm);
    put_half({3'b101, sign ? 8'h10 : 8'h11, ra});
    put_half(imm);
    regs_m[ra] = sign ? {{16{imm[15]}}, imm} : {16'h0000, imm};
  endtask

  task automatic reg_alu(input logic [3:0] op, input logic [4:0] ra, rb, rc);
    put_half({3'b011, 3'b000, rb, ra});
    put_half({1'b0, op, 6'd0, rc});
    regs_m[ra] = alu_ref(op, regs_m[rb], regs_m[rc]);
  endtask

  task automatic imm_alu(input logic [3:0] op, input logic [4:0] ra, rb, input logic [15:0] imm);
    put_half({3'b001, 3'b000, rb, ra});
    put_half({1'b0, op, 11'd0});
    put_half(imm);
    regs_m[ra] = alu_ref(op, regs_m[rb], {{16{imm[15]}}, imm});
  endtask

  task automatic inh_op(input logic [2:0] op, input logic [4:0] ra, rb);
    put_half({3'b100, op, rb, ra});
    case (op)
      3'd2: ccr_m = sub_flags(regs_m[ra], regs_m[rb]); // cmp
      3'd3: regs_m[ra] = regs_m[ra] + 32'd1;
      3'd4: regs_m[ra] = regs_m[ra] - 32'd1;
      3'd7: regs_m[ra] = regs_m[rb];
      default: ;
    endcase
  endtask

  task automatic indirect_op(input logic [7:0] op, input logic [4:0] ra, rb,
                             input logic [10:0] off);
    logic [31:0] ea;
    ea = regs_m[rb] + {{21{off[10]}}, off};
    put_half({3'b010, op[7:5], rb, ra});
    put_half({op[4:0], off});
    case (op)
      8'h00: expect_word(ea, regs_m[ra]);
      8'h01: regs_m[ra] = preload_word; // only the preloaded word is loaded
      8'h0a: regs_m[ra] = ea;
      default: ;
    endcase
  endtask

  task automatic std_raw(input logic [4:0] ra, input logic [31:0] addr);
    put_half({3'b110, 8'h00, ra});
    put_half(addr[31:16]);
    put_half(addr[15:0]);
  endtask

  task automatic store_word(input logic [4:0] ra);
    std_raw(ra, dptr);
    expect_word(dptr, regs_m[ra]);
    dptr = dptr + 32'd4;
  endtask

  // both paths of a bcc meet at one store
  task automatic branch_case(input logic [3:0] cond, input logic [15:0] tag);
    logic taken;
    taken = branch_rule(cond, ccr_m);
    put_half({3'b101, 4'h0, cond, 5'd0});
    put_half(16'd8);
    put_half({3'b101, 8'h11, 5'd9});
    put_half(tag);
    put_half({3'b101, 8'h00, 5'd0});
    put_half(16'd4);
    put_half({3'b101, 8'h11, 5'd9});
    put_half(tag | 16'h8000);
    regs_m[9] = {16'h0000, taken ? (tag | 16'h8000) : tag};
    store_word(9);
  endtask

  task automatic build_program();
    logic [31:0] target;
    foreach (regs_m[i]) regs_m[i] = '0;
    ccr_m = '0;
    dptr  = 32'h0000_1000;
    load_imm32(1, 32'h1234_5678);
    store_word(1);
    for (int p = 0; p < 3; p++) begin
      load_imm32(2, pair_a[p]);
      load_imm32(3, pair_b[p]);
      for (int op = 0; op <= 6; op++) begin
        reg_alu(4'(op), 4, 2, 3);
        store_word(4);
      end
      inh_op(3'd2, 2, 3);
      store_word(2); // ccr checked on this store
      for (int c = 0; c < 12; c++) begin
        branch_case(4'(c), 16'(p * 16 + c));
      end
    end
    for (int op = 0; op <= 6; op++) begin
      imm_alu(4'(op), 6, 2, 16'h8421);
      store_word(6);
    end
    load_imm16(1'b1, 7, 16'h8001);
    store_word(7);
    load_imm16(1'b0, 7, 16'h8001);
    store_word(7);
    inh_op(3'd3, 7, 0);
    store_word(7);
    inh_op(3'd4, 2, 0);
    store_word(2);
    inh_op(3'd7, 8, 2);
    store_word(8);
    inh_op(3'd0, 0, 0);
    load_imm32(12, preload_addr - 32'h10);
    indirect_op(8'h01, 13, 12, 11'h010); // ld.l
    indirect_op(8'h00, 13, 12, 11'h7f0); // st.l at rB - 16
    target = pc_now() + 32'd12;          // jmpd and a skipped std.l
    put_half({3'b110, 8'h80, 5'd0});
    put_half(target[31:16]);
    put_half(target[15:0]);
    std_raw(1, 32'h0000_2000);
    load_imm16(1'b0, 9, 16'h0d1d);
    store_word(9);
    target = pc_now() + 32'd16;          // ldi, jmp and a skipped std.l
    load_imm32(10, target - 32'h20);
    indirect_op(8'ha0, 0, 10, 11'h020);
    std_raw(1, 32'h0000_2004);
    load_imm16(1'b0, 9, 16'h0a1a);
    store_word(9);
    indirect_op(8'h0a, 11, 10, 11'h7fc); // lda
    store_word(11);
    put_half(16'h0000);                  // undefined opcode
    put_half(16'h0000);
    std_raw(1, 32'h0000_2008);           // never reached once the core faults
  endtask

  task automatic wait_write(input int idx);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!(mem_valid && mem_ready && mem_write)) begin
      cycles++;
      if (cycles >= timeout_cycles) begin
        stop_run($sformatf("timeout: write %0d did not appear within %0d cycles",
                           idx, timeout_cycles));
      end
      @(negedge clk);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // memory side with random ready
  initial begin
    mem_ready = 1'b0;
    mem_rdata = '0;
    forever begin
      @(posedge clk);
      #10;
      rng_state = next_rand(rng_state);
      mem_ready = rng_state[0];
      mem_rdata = mem_read(mem_addr);
    end
  end

  always @(negedge clk) begin
    if (mem_valid && mem_ready && mem_write) begin
      if (mem_addr >= cpu_pkg::reset_pc) prog_mem[mem_addr - cpu_pkg::reset_pc] = mem_wdata;
      else data_mem[mem_addr] = mem_wdata;
    end
  end

  initial begin
    rst_n = 1'b0;
    $timeformat(-9, 0, " ns", 0);
    build_program();
    foreach (prog[i]) prog_mem[32'(2 * i)] = prog[i];
    data_mem[preload_addr]         = preload_word[31:16];
    data_mem[preload_addr + 32'd2] = preload_word[15:0];
    repeat (5) @(posedge clk);
    #10 rst_n = 1'b1;
    @(negedge clk);
    check_equal("ccr after reset", 32'(ccr), 32'd0);
    check_equal("mem_write after reset", 32'(mem_write), 32'd0);
    check_equal("first fetch address", mem_addr, cpu_pkg::reset_pc);
    for (int i = 0; i < exp_addr.size(); i++) begin
      wait_write(i);
      check_equal($sformatf("write %0d address", i), mem_addr, exp_addr[i]);
      check_equal($sformatf("write %0d data", i), 32'(mem_wdata), 32'(exp_data[i]));
      check_equal($sformatf("write %0d ccr", i), 32'(ccr), 32'(exp_ccr[i]));
    end
    repeat (quiet_cycles) begin
      @(negedge clk);
      if (mem_valid && mem_write) begin
        stop_run("a memory write appeared after the undefined opcode");
      end
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: project.f
hw/cpu_pkg.sv
hw/mem_bus_if.sv
hw/ls_if.sv
hw/fetch_unit.sv
hw/load_store_unit.sv
hw/bus_arbiter.sv
hw/alu.sv
hw/regfile.sv
hw/exec_control.sv
hw/cpu_top.sv
bench/tb_cpu_top.sv

// File: Makefile
TOP := tb_cpu_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/100ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f project.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir
